//--- files.f
+incdir+include
hw/blk_pkg.sv
hw/blk_if.sv
hw/delay_line.sv
hw/pix_metrics.sv
hw/blk_accum.sv
hw/blk_decide.sv
hw/blk_detect_top.sv
test/blk_detect_properties.sv
test/tb_blk_detect.sv

//--- hw/blk_accum.sv
`include "blk_params.svh"

module blk_accum import blk_pkg::*; (
   input logic clk_i,
   input logic rst_ni,
   metric_if.dst m_i,
   output logic seg_valid_o,
   output blk_sums_t seg_sums_o,
   output logic row_done_o
);

   localparam int CNT_W = $clog2(`BLK_HBLKS + 1);

   blk_sums_t acc_q;
   blk_sums_t lbuf_head;
   blk_sums_t total;
   logic [CNT_W-1:0] first_cnt_q;
   logic first_line;

   // Segment accumulator empties after each h_save
   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         acc_q <= '0;
      end else if (m_i.h_save) begin
         acc_q <= '0;
      end else if (m_i.valid) begin
         acc_q.y <= acc_q.y + y_sum_t'(m_i.metric.luma);
         acc_q.c <= acc_q.c + c_sum_t'(m_i.metric.chroma);
         acc_q.l <= acc_q.l + l_sum_t'(m_i.metric.light);
      end
   end

   // Counts the segments of the first line in a block row
   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         first_cnt_q <= CNT_W'(`BLK_HBLKS);
      end else if (m_i.v_save) begin
         first_cnt_q <= CNT_W'(`BLK_HBLKS);
      end else if (m_i.h_save && first_line) begin
         first_cnt_q <= first_cnt_q - 1'b1;
      end
   end

   assign first_line = |first_cnt_q;

   always_comb begin
      total = acc_q;
      if (!first_line) begin // Add the partial sum of the lines above
         total.y = acc_q.y + lbuf_head.y;
         total.c = acc_q.c + lbuf_head.c;
         total.l = acc_q.l + lbuf_head.l;
      end
   end

   delay_line #(
      .T (blk_sums_t),
      .DEPTH (`BLK_HBLKS)
   ) u_lbuf (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .en_i (m_i.h_save),
      .d_i (total),
      .d_o (lbuf_head)
   );

   always_ff @(posedge clk_i) begin
      if (m_i.h_save) seg_sums_o <= total;
   end

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         seg_valid_o <= 1'b0;
         row_done_o <= 1'b0;
      end else begin
         seg_valid_o <= m_i.h_save;
         row_done_o <= m_i.v_save;
      end
   end

endmodule

//--- hw/blk_decide.sv
`include "blk_params.svh"

module blk_decide import blk_pkg::*; (
   input logic clk_i,
   input logic rst_ni,
   input logic seg_valid_i,
   input blk_sums_t seg_sums_i,
   input logic row_done_i,
   output logic row_valid_o,
   output blk_row_t row_o
);

   localparam y_sum_t Y_LO = y_sum_t'(`BLK_Y_THR - `BLK_Y_HYS);
   localparam y_sum_t Y_HI = y_sum_t'(`BLK_Y_THR + `BLK_Y_HYS);
   localparam c_sum_t C_LO = c_sum_t'(`BLK_C_THR - `BLK_C_HYS);
   localparam c_sum_t C_HI = c_sum_t'(`BLK_C_THR + `BLK_C_HYS);
   localparam l_sum_t L_LO = l_sum_t'(`BLK_L_THR - `BLK_L_HYS);
   localparam l_sum_t L_HI = l_sum_t'(`BLK_L_THR + `BLK_L_HYS);

   blk_row_t cur_q;
   blk_row_t prev_q;
   blk_row_t store_out;
   logic y_flag;
   logic c_flag;
   logic l_flag;

   // Lower bar when the block was set in the previous frame
   assign y_flag = seg_sums_i.y >= (prev_q.y_flags[0] ? Y_LO : Y_HI);
   assign c_flag = seg_sums_i.c >= (prev_q.c_flags[0] ? C_LO : C_HI);
   assign l_flag = seg_sums_i.l >= (prev_q.l_flags[0] ? L_LO : L_HI);

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         cur_q <= '0;
         prev_q <= '0;
      end else if (row_done_i) begin
         prev_q <= store_out; // Same block row in the previous frame
      end else if (seg_valid_i) begin
         cur_q.y_flags <= {y_flag, cur_q.y_flags[`BLK_HBLKS-1:1]};
         cur_q.c_flags <= {c_flag, cur_q.c_flags[`BLK_HBLKS-1:1]};
         cur_q.l_flags <= {l_flag, cur_q.l_flags[`BLK_HBLKS-1:1]};
         prev_q.y_flags <= {prev_q.y_flags[0], prev_q.y_flags[`BLK_HBLKS-1:1]};
         prev_q.c_flags <= {prev_q.c_flags[0], prev_q.c_flags[`BLK_HBLKS-1:1]};
         prev_q.l_flags <= {prev_q.l_flags[0], prev_q.l_flags[`BLK_HBLKS-1:1]};
      end
   end

   // Holds the other block rows of the previous frame
   delay_line #(
      .T (blk_row_t),
      .DEPTH (`BLK_VBLKS - 1)
   ) u_frame_store (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .en_i (row_done_i),
      .d_i (cur_q),
      .d_o (store_out)
   );

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         row_valid_o <= 1'b0;
         row_o <= '0;
      end else begin
         row_valid_o <= row_done_i;
         if (row_done_i) row_o <= cur_q;
      end
   end

endmodule

//--- hw/blk_detect_top.sv
module blk_detect_top import blk_pkg::*; (
   input logic clk_i,
   input logic rst_ni,
   input logic de_i,
   input logic h_save_i,
   input logic v_save_i,
   input pixel_t pixel_i,
   output logic row_valid_o,
   output flags_t y_flags_o,
   output flags_t c_flags_o,
   output flags_t l_flags_o
);

   metric_if m_bus ();

   logic seg_valid;
   blk_sums_t seg_sums;
   logic row_done;
   blk_row_t row;

   pix_metrics u_pix (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .de_i (de_i),
      .h_save_i (h_save_i),
      .v_save_i (v_save_i),
      .pixel_i (pixel_i),
      .m_o (m_bus.src)
   );

   blk_accum u_accum (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .m_i (m_bus.dst),
      .seg_valid_o (seg_valid),
      .seg_sums_o (seg_sums),
      .row_done_o (row_done)
   );

   blk_decide u_decide (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .seg_valid_i (seg_valid),
      .seg_sums_i (seg_sums),
      .row_done_i (row_done),
      .row_valid_o (row_valid_o),
      .row_o (row)
   );

   assign y_flags_o = row.y_flags;
   assign c_flags_o = row.c_flags;
   assign l_flags_o = row.l_flags;

endmodule

//--- hw/blk_if.sv
interface metric_if import blk_pkg::*; ();

   logic valid;
   metric_t metric;
   logic h_save;
   logic v_save;

   // Input side
   modport src (
      output valid,
      output metric,
      output h_save,
      output v_save
   );

   // Accumulator side
   modport dst (
      input valid,
      input metric,
      input h_save,
      input v_save
   );

endinterface

//--- hw/blk_pkg.sv
`include "blk_params.svh"

package blk_pkg;

   typedef struct packed {
      logic [7:0] r; // Top byte
      logic [7:0] g;
      logic [7:0] b;
   } pixel_t;

   typedef struct packed {
      logic [16:0] luma; // 109 R + 37 G + 366 B
      logic [7:0] chroma; // max - min
      logic [8:0] light; // max + min
   } metric_t;

   typedef logic [`BLK_Y_W-1:0] y_sum_t;
   typedef logic [`BLK_C_W-1:0] c_sum_t;
   typedef logic [`BLK_L_W-1:0] l_sum_t;

   typedef struct packed {
      y_sum_t y;
      c_sum_t c;
      l_sum_t l;
   } blk_sums_t;

   typedef logic [`BLK_HBLKS-1:0] flags_t;

   typedef struct packed {
      flags_t y_flags;
      flags_t c_flags;
      flags_t l_flags;
   } blk_row_t;

endpackage

//--- hw/delay_line.sv
module delay_line #(
   parameter type T = logic [7:0],
   parameter int DEPTH = 2
) (
   input logic clk_i,
   input logic rst_ni,
   input logic en_i,
   input T d_i,
   output T d_o
);

   T stage_q [DEPTH];

   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         for (int i = 0; i < DEPTH; i++) stage_q[i] <= '0;
      end else if (en_i) begin
         stage_q[0] <= d_i;
         for (int i = 1; i < DEPTH; i++) stage_q[i] <= stage_q[i-1];
      end
   end

   assign d_o = stage_q[DEPTH-1]; // Oldest entry

endmodule

//--- hw/pix_metrics.sv
module pix_metrics import blk_pkg::*; (
   input logic clk_i,
   input logic rst_ni,
   input logic de_i,
   input logic h_save_i,
   input logic v_save_i,
   input pixel_t pixel_i,
   metric_if.src m_o
);

   logic [7:0] max_c;
   logic [7:0] min_c;
   logic [16:0] luma;

   always_comb begin
      max_c = pixel_i.r;
      min_c = pixel_i.r;
      if (pixel_i.g > max_c) max_c = pixel_i.g;
      if (pixel_i.b > max_c) max_c = pixel_i.b;
      if (pixel_i.g < min_c) min_c = pixel_i.g;
      if (pixel_i.b < min_c) min_c = pixel_i.b;
   end

   // Weights sum to 512
   assign luma = {9'b0, pixel_i.r} * 17'd109
               + {9'b0, pixel_i.g} * 17'd37
               + {9'b0, pixel_i.b} * 17'd366;

   always_ff @(posedge clk_i) begin
      if (de_i) begin
         m_o.metric.luma <= luma;
         m_o.metric.chroma <= max_c - min_c;
         m_o.metric.light <= {1'b0, max_c} + {1'b0, min_c};
      end
   end

   // Strobes stay aligned with the metrics
   always_ff @(posedge clk_i, negedge rst_ni) begin
      if (!rst_ni) begin
         m_o.valid <= 1'b0;
         m_o.h_save <= 1'b0;
         m_o.v_save <= 1'b0;
      end else begin
         m_o.valid <= de_i;
         m_o.h_save <= h_save_i;
         m_o.v_save <= v_save_i;
      end
   end

endmodule

//--- include/blk_params.svh
`ifndef BLK_PARAMS_SVH
`define BLK_PARAMS_SVH

// Block grid and block size
`define BLK_HBLKS 4
`define BLK_VBLKS 3
`define BLK_PXS 4 // 2 by 2 pixels

// Block sum widths
`define BLK_Y_W 20
`define BLK_C_W 11
`define BLK_L_W 12

`define BLK_Y_THR (`BLK_PXS * 512 * 128)
`define BLK_Y_HYS (`BLK_PXS * 512 * 8)
`define BLK_C_THR (`BLK_PXS * 89) // About 0.35 of full scale
`define BLK_C_HYS (`BLK_PXS * 5)
`define BLK_L_THR (`BLK_PXS * 256)
`define BLK_L_HYS (`BLK_PXS * 15)

`endif

//--- run.sh
#!/usr/bin/env bash
# Builds the block statistics testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
   --top-module tb_blk_detect -f files.f -o sim_blk_detect
status=$?
if [ $status -ne 0 ]; then
   echo "Verilator build failed with status $status"
   exit 1
fi

./obj_dir/sim_blk_detect
status=$?
if [ $status -ne 0 ]; then
   echo "Simulation failed with status $status"
   exit 1
fi

exit 0

//--- test/blk_detect_properties.sv
module blk_detect_properties (
   input logic clk_i,
   input logic rst_ni,
   input logic de_i,
   input logic h_save_i,
   input logic v_save_i,
   input logic row_valid_i
);
   timeunit 1ns;
   timeprecision 100ps;

   // Three pipeline stages from row end to row result
   a_row_latency: assert property (@(posedge clk_i) disable iff (!rst_ni)
      v_save_i |-> ##3 row_valid_i)
      else $error("row_valid_o did not follow v_save_i after 3 cycles");

   a_row_cause: assert property (@(posedge clk_i) disable iff (!rst_ni)
      row_valid_i |-> $past(v_save_i, 3))
      else $error("row_valid_o without a v_save_i 3 cycles before");

   // Segment end strobe comes only in a blank cycle
   a_hsave_blank: assert property (@(posedge clk_i) disable iff (!rst_ni)
      !(h_save_i && de_i))
      else $error("h_save_i and de_i high in the same cycle");

endmodule

//--- test/blk_golden.txt
// frame row col line0_rgb line1_rgb y_flag c_flag l_flag (all hex)
// Two pixels per line and block, two lines per block
0 0 0 202020 202020 0 0 0
0 0 1 E0E0E0 E0E0E0 1 0 1
0 0 2 FFFFFF 404040 1 0 1
0 0 3 C00000 C00000 0 1 0
0 1 0 F0F0F0 F0F0F0 1 0 1
0 1 1 101010 101010 0 0 0
0 1 2 00FF00 00FF00 0 1 0
0 1 3 2020FF 2020FF 1 1 1
0 2 0 808080 808080 0 0 0
0 2 1 8C8C8C 8C8C8C 1 0 1
0 2 2 00FFFF 00FFFF 1 1 0
0 2 3 FF0000 FFFF00 0 1 0
1 0 0 808080 808080 0 0 0
1 0 1 808080 808080 1 0 1
1 0 2 404040 404040 0 0 0
1 0 3 580000 580000 0 1 0
1 1 0 787878 787878 1 0 0
1 1 1 FFFFFF FFFFFF 1 0 1
1 1 2 004000 004000 0 0 0
1 1 3 2020FF 3030F0 1 1 1
1 2 0 A0A0A0 909090 1 0 1
1 2 1 7C7C7C 7C7C7C 1 0 1
1 2 2 00A0A0 00A0A0 1 1 0
1 2 3 602010 602010 0 0 0

//--- test/tb_blk_detect.sv
`include "blk_params.svh"

module tb_blk_detect import blk_pkg::*; ();
   timeunit 1ns;
   timeprecision 100ps;

   localparam int FIELDS = 8; // Words per golden line
   localparam int BLOCKS = 2 * `BLK_VBLKS * `BLK_HBLKS;
   localparam int ROW_TIMEOUT = 10;

   logic clk;
   logic rst_n;
   logic de;
   logic h_save;
   logic v_save;
   pixel_t pixel;
   logic row_valid;
   flags_t y_flags;
   flags_t c_flags;
   flags_t l_flags;

   logic [23:0] gold [BLOCKS * FIELDS];
   logic [31:0] rnd;

   blk_detect_top dut0 (
      .clk_i (clk),
      .rst_ni (rst_n),
      .de_i (de),
      .h_save_i (h_save),
      .v_save_i (v_save),
      .pixel_i (pixel),
      .row_valid_o (row_valid),
      .y_flags_o (y_flags),
      .c_flags_o (c_flags),
      .l_flags_o (l_flags)
   );

   bind blk_detect_top blk_detect_properties u_props (
      .clk_i (clk_i),
      .rst_ni (rst_ni),
      .de_i (de_i),
      .h_save_i (h_save_i),
      .v_save_i (v_save_i),
      .row_valid_i (row_valid_o)
   );

   initial begin
      clk = 1'b0;
      forever #2 clk = ~clk;
   end

   function automatic logic [31:0] lcg_next(input logic [31:0] s);
      return s * 32'd1103515245 + 32'd12345;
   endfunction

   task automatic drive_cycle(input logic de_v, input logic hs_v, input logic vs_v,
                              input pixel_t px);
      @(negedge clk);
      de = de_v;
      h_save = hs_v;
      v_save = vs_v;
      pixel = px;
   endtask

   task automatic send_segment(input pixel_t color);
      drive_cycle(1'b1, 1'b0, 1'b0, color);
      drive_cycle(1'b1, 1'b0, 1'b0, color);
      drive_cycle(1'b0, 1'b1, 1'b0, '0); // Segment end
   endtask

   task automatic idle_gap();
      int n;
      rnd = lcg_next(rnd);
      n = int'(rnd[17:16]); // 0 to 3 blank cycles
      repeat (n) drive_cycle(1'b0, 1'b0, 1'b0, '0);
   endtask

   task automatic compare_flag(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("FAIL %s: expected %b, actual %b", name, exp, act);
         $display("TEST FAILED");
         $fatal(1, "flag mismatch");
      end
   endtask

   task automatic compare_row(input string name, input blk_row_t exp, input blk_row_t act);
      if (act !== exp) begin
         $display("FAIL %s: expected y=%b c=%b l=%b, actual y=%b c=%b l=%b", name,
                  exp.y_flags, exp.c_flags, exp.l_flags,
                  act.y_flags, act.c_flags, act.l_flags);
         $display("TEST FAILED");
         $fatal(1, "flag row mismatch");
      end
   endtask

   task automatic wait_row_valid(input string name);
      int cycles;
      cycles = 0;
      while (row_valid !== 1'b1) begin
         if (cycles == ROW_TIMEOUT) begin
            $display("Timeout in %s: row_valid_o never came after v_save_i", name);
            $display("TEST FAILED");
            $fatal(1, "missing row strobe");
         end else begin
            drive_cycle(1'b0, 1'b0, 1'b0, '0);
            cycles++;
         end
      end
   endtask

   // Golden lines must run in frame, row, column order
   task automatic check_golden_order();
      int base;
      for (int i = 0; i < BLOCKS; i++) begin
         base = i * FIELDS;
         if (gold[base] !== 24'(i / (`BLK_VBLKS * `BLK_HBLKS)) ||
             gold[base + 1] !== 24'((i / `BLK_HBLKS) % `BLK_VBLKS) ||
             gold[base + 2] !== 24'(i % `BLK_HBLKS)) begin
            $display("Golden file line %0d is missing or out of order", i);
            $display("TEST FAILED");
            $fatal(1, "bad golden file");
         end
      end
   endtask

   function automatic blk_row_t expected_row(input int f, input int r);
      blk_row_t row;
      int base;
      row = '0;
      for (int c = 0; c < `BLK_HBLKS; c++) begin
         base = ((f * `BLK_VBLKS + r) * `BLK_HBLKS + c) * FIELDS;
         row.y_flags[c] = gold[base + 5][0];
         row.c_flags[c] = gold[base + 6][0];
         row.l_flags[c] = gold[base + 7][0];
      end
      return row;
   endfunction

   initial begin
      int idx;
      string name;
      blk_row_t last_row;
      rst_n = 1'b0;
      de = 1'b0;
      h_save = 1'b0;
      v_save = 1'b0;
      pixel = '0;
      rnd = 32'd49;
      last_row = '0;
      $readmemh("test/blk_golden.txt", gold);
      check_golden_order();
      repeat (2) @(negedge clk);
      rst_n = 1'b1;

      // Nothing reported before the first row end
      repeat (4) begin
         drive_cycle(1'b0, 1'b0, 1'b0, '0);
         compare_flag("reset row_valid", 1'b0, row_valid);
         compare_row("reset flags", '0, blk_row_t'({y_flags, c_flags, l_flags}));
      end

      for (int f = 0; f < 2; f++) begin
         for (int r = 0; r < `BLK_VBLKS; r++) begin
            name = $sformatf("frame %0d row %0d", f, r);
            for (int ln = 0; ln < 2; ln++) begin
               for (int c = 0; c < `BLK_HBLKS; c++) begin
                  idx = ((f * `BLK_VBLKS + r) * `BLK_HBLKS + c) * FIELDS;
                  send_segment(pixel_t'(gold[idx + 3 + ln]));
                  idle_gap();
               end
            end
            // Previous row stays on the outputs until the next strobe
            compare_row({name, " held"}, last_row,
                        blk_row_t'({y_flags, c_flags, l_flags}));
            drive_cycle(1'b0, 1'b0, 1'b1, '0); // Block row end
            wait_row_valid(name);
            last_row = expected_row(f, r);
            compare_row(name, last_row, blk_row_t'({y_flags, c_flags, l_flags}));
         end
      end

      $display("TEST OK");
      $finish;
   end

endmodule
